/* all.f */
hdl/pm_pkg.sv
hdl/pm_apb_regs.sv
hdl/pm_frame_history.sv
hdl/pm_image_error.sv
hdl/pm_move_ctl.sv
hdl/pm_stepper.sv
hdl/pm_top.sv
tests/pm_tb.sv

/* hdl/pm_apb_regs.sv */
`timescale 1ns/10ps

module pm_apb_regs (
	input logic clk,
	input logic resetn,

	input logic [pm_pkg::apb_aw-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	output pm_pkg::cmd_word_t cmd,
	output logic [pm_pkg::step_w-1:0] speed,
	output logic [pm_pkg::frmn_w-1:0] delay_frm,
	output logic go_pulse,
	output logic lut_we,
	output logic [pm_pkg::img_w-1:0] lut_addr,
	output logic [pm_pkg::step_w-1:0] lut_wdata,

	input logic done,
	input logic over,
	input logic running
);

	logic access;
	logic reg_hit;
	logic lut_hit;
	logic wr_ok;
	logic [pm_pkg::apb_aw-1:0] lut_off;

	assign access = psel & penable;
	assign lut_hit = (paddr >= pm_pkg::addr_lut_base) && (paddr < pm_pkg::addr_lut_end);
	assign lut_off = paddr - pm_pkg::addr_lut_base;

	always_comb begin
		case (paddr)
			pm_pkg::addr_cmd,
			pm_pkg::addr_speed,
			pm_pkg::addr_delay,
			pm_pkg::addr_ctrl,
			pm_pkg::addr_status: reg_hit = 1'b1;
			default: reg_hit = 1'b0;
		endcase
	end

	// no wait states
	assign pready = 1'b1;
	assign pslverr = access & (~(reg_hit | lut_hit) | (pwrite & (paddr == pm_pkg::addr_status)));
	assign wr_ok = access & pwrite & ~pslverr;

	always_comb begin
		case (paddr)
			pm_pkg::addr_cmd: prdata = cmd;
			pm_pkg::addr_speed: prdata = speed;
			pm_pkg::addr_delay: prdata = 32'(delay_frm);
			pm_pkg::addr_status: prdata = {29'd0, running, over, done};
			// ctrl and table read back as zero
			default: prdata = 32'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cmd <= '0;
			speed <= '0;
			delay_frm <= '0;
			go_pulse <= 1'b0;
		end else begin
			go_pulse <= wr_ok & (paddr == pm_pkg::addr_ctrl) & pwdata[0];
			if (wr_ok && paddr == pm_pkg::addr_cmd)
				cmd <= pwdata;
			if (wr_ok && paddr == pm_pkg::addr_speed)
				speed <= pwdata;
			if (wr_ok && paddr == pm_pkg::addr_delay)
				delay_frm <= pwdata[pm_pkg::frmn_w-1:0];
		end
	end

	// table write strobe, one cycle after the access
	always_ff @(posedge clk) begin
		if (!resetn)
			lut_we <= 1'b0;
		else
			lut_we <= wr_ok & lut_hit;
	end

	always_ff @(posedge clk) begin
		if (wr_ok && lut_hit) begin
			lut_addr <= lut_off[pm_pkg::img_w+1:2];
			lut_wdata <= pwdata;
		end
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (!resetn)
		penable |-> psel);

endmodule

/* hdl/pm_frame_history.sv */
`timescale 1ns/10ps

module pm_frame_history (
	input logic clk,
	input logic resetn,
	input logic img_pulse,
	input logic [pm_pkg::frmn_w-1:0] delay_frm,
	input logic [pm_pkg::step_w-1:0] m_position,
	output logic [pm_pkg::step_w-1:0] movie_pos
);

	// entry 0 is the newest capture
	logic [pm_pkg::step_w-1:0] hist [pm_pkg::hist_depth];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < pm_pkg::hist_depth; i++)
				hist[i] <= '0;
		end else if (img_pulse) begin
			hist[0] <= m_position;
			for (int i = 1; i < pm_pkg::hist_depth; i++)
				hist[i] <= hist[i-1];
		end
	end

	// position the stage had when the measured frame was exposed
	assign movie_pos = hist[delay_frm];

endmodule

/* hdl/pm_image_error.sv */
`timescale 1ns/10ps

module pm_image_error (
	input logic clk,
	input logic resetn,
	input logic start,
	input pm_pkg::cmd_word_t cmd,
	input logic [pm_pkg::img_w-1:0] img_pos,
	input logic lut_we,
	input logic [pm_pkg::img_w-1:0] lut_addr,
	input logic [pm_pkg::step_w-1:0] lut_wdata,
	output logic err_valid,
	output logic err_ok,
	output logic err_back,
	output logic [pm_pkg::step_w-1:0] err_steps
);

	logic v1, v2, v3;

	logic [pm_pkg::img_w-1:0] pos_c;
	logic [pm_pkg::img_w-1:0] pos_d;
	logic [pm_pkg::img_w-1:0] pos_l;
	logic [pm_pkg::img_w:0] pos_r;

	logic below, above, back2;
	logic [pm_pkg::img_w-1:0] diff_dn;
	logic [pm_pkg::img_w-1:0] diff_up;
	logic [pm_pkg::img_w-1:0] rd_addr;

	logic ok3, back3;
	logic [pm_pkg::step_w-1:0] rd_q;

	// pixel error to step count
	logic [pm_pkg::step_w-1:0] lut [pm_pkg::lut_depth];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			ok3 <= 1'b0;
			back3 <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			v3 <= v2;
			if (v2) begin
				ok3 <= ~(below | above);
				back3 <= back2;
			end
		end
	end

	// stage 1, window limits
	always_ff @(posedge clk) begin
		if (start) begin
			pos_c <= img_pos;
			pos_d <= cmd.img.dst;
			// lower edge clamps at pixel zero
			if (cmd.img.tol > cmd.img.dst)
				pos_l <= '0;
			else
				pos_l <= cmd.img.dst - cmd.img.tol;
			pos_r <= {1'b0, cmd.img.dst} + {1'b0, cmd.img.tol};
		end
	end

	// stage 2, compare and both differences
	always_ff @(posedge clk) begin
		if (v1) begin
			below <= pos_c < pos_l;
			above <= {1'b0, pos_c} > pos_r;
			back2 <= pos_c < pos_d;
			diff_dn <= pos_d - pos_c;
			diff_up <= pos_c - pos_d;
		end
	end

	// stage 3, table read at the absolute error
	assign rd_addr = back2 ? diff_dn : diff_up;

	always_ff @(posedge clk) begin
		if (v2)
			rd_q <= lut[rd_addr];
	end

	always_ff @(posedge clk) begin
		if (lut_we)
			lut[lut_addr] <= lut_wdata;
	end

	assign err_valid = v3;
	assign err_ok = ok3;
	assign err_back = back3;
	assign err_steps = ok3 ? '0 : rd_q;

endmodule

/* hdl/pm_move_ctl.sv */
`timescale 1ns/10ps

module pm_move_ctl (
	input logic clk,
	input logic resetn,
	input logic go_pulse,
	input pm_pkg::cmd_word_t cmd,
	input logic img_pulse,
	input logic img_valid,
	input logic err_valid,
	input logic err_ok,
	input logic err_back,
	input logic [pm_pkg::step_w-1:0] err_steps,
	input logic [pm_pkg::step_w-1:0] movie_pos,
	input logic m_running,
	output logic img_start,
	output logic m_start,
	output logic [pm_pkg::step_w-1:0] m_step,
	output logic m_dir,
	output logic exe_done,
	output logic over
);

	logic armed;
	logic pend;
	logic wait_run;
	logic busy;
	logic go_ok;
	logic start_abs;
	logic check;
	logic start_img;

	// a go during a run is dropped
	assign busy = m_running | m_start | wait_run;
	assign go_ok = go_pulse & ~busy;
	assign start_abs = go_ok & ~cmd.abs.mode;

	assign img_start = armed & img_pulse & img_valid;
	assign check = err_valid & pend;
	assign start_img = check & ~err_ok & (err_back == cmd.img.dir);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			pend <= 1'b0;
			wait_run <= 1'b0;
			m_start <= 1'b0;
			exe_done <= 1'b0;
			over <= 1'b0;
		end else begin
			m_start <= 1'b0;
			if (go_pulse)
				exe_done <= 1'b0;
			if (go_ok) begin
				over <= 1'b0;
				pend <= 1'b0;
				armed <= cmd.abs.mode;
				if (start_abs) begin
					m_start <= 1'b1;
					wait_run <= 1'b1;
				end
			end else begin
				if (img_start) begin
					armed <= 1'b0;
					pend <= 1'b1;
				end
				if (check) begin
					pend <= 1'b0;
					if (start_img) begin
						m_start <= 1'b1;
						wait_run <= 1'b1;
					end else begin
						// inside the window, or the stage would have to reverse
						over <= ~err_ok;
						exe_done <= 1'b1;
					end
				end
				// stepper has taken the start and gone idle again
				if (wait_run && !m_start && !m_running) begin
					wait_run <= 1'b0;
					exe_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_abs) begin
			m_step <= pm_pkg::step_w'(cmd.abs.steps);
			m_dir <= cmd.abs.dir;
		end else if (start_img) begin
			m_step <= err_steps;
			m_dir <= err_back;
		end
	end

	a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
		$rose(m_start) |-> !m_running);

endmodule

/* hdl/pm_pkg.sv */
package pm_pkg;

	// image and motor widths
	localparam int img_w = 12;
	localparam int step_w = 32;
	localparam int frmn_w = 2;

	// history keeps the current frame plus up to three older ones
	localparam int hist_depth = 1 << frmn_w;

	// one table entry per possible pixel error
	localparam int lut_depth = 1 << img_w;

	// apb address width covers the table window
	localparam int apb_aw = 16;

	localparam logic [apb_aw-1:0] addr_cmd = 16'h0000;
	localparam logic [apb_aw-1:0] addr_speed = 16'h0004;
	localparam logic [apb_aw-1:0] addr_delay = 16'h0008;
	localparam logic [apb_aw-1:0] addr_ctrl = 16'h000C;
	localparam logic [apb_aw-1:0] addr_status = 16'h0010;
	localparam logic [apb_aw-1:0] addr_lut_base = 16'h1000;
	localparam logic [apb_aw-1:0] addr_lut_end = apb_aw'(32'h1000 + 4 * lut_depth);

	// move command, mode bit picks the view
	typedef union packed {
		struct packed {
			logic mode;
			logic dir;
			logic [29:0] steps;
		} abs;
		struct packed {
			logic mode;
			logic dir;
			logic [img_w-1:0] dst;
			logic [img_w-1:0] tol;
			logic [5:0] unused;
		} img;
	} cmd_word_t;

endpackage

/* hdl/pm_stepper.sv */
`timescale 1ns/10ps

module pm_stepper (
	input logic clk,
	input logic resetn,
	input logic m_start,
	input logic [pm_pkg::step_w-1:0] m_step,
	input logic m_dir,
	input logic [pm_pkg::step_w-1:0] speed,
	output logic m_running,
	output logic [pm_pkg::step_w-1:0] m_position
);

	logic [pm_pkg::step_w-1:0] remain;
	logic [pm_pkg::step_w-1:0] div_cnt;
	logic [pm_pkg::step_w-1:0] spd_q;
	logic dir_q;

	// run settings held for the whole run
	always_ff @(posedge clk) begin
		if (m_start && !m_running) begin
			spd_q <= speed;
			dir_q <= m_dir;
		end
	end

	// position is a two's complement count
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_running <= 1'b0;
			remain <= '0;
			div_cnt <= '0;
			m_position <= '0;
		end else if (!m_running) begin
			// zero steps finishes without ever running
			if (m_start && m_step != '0) begin
				m_running <= 1'b1;
				remain <= m_step;
				div_cnt <= '0;
			end
		end else if (div_cnt == spd_q) begin
			div_cnt <= '0;
			remain <= remain - 1'b1;
			if (dir_q)
				m_position <= m_position - 1'b1;
			else
				m_position <= m_position + 1'b1;
			if (remain == pm_pkg::step_w'(1))
				m_running <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* hdl/pm_top.sv */
`timescale 1ns/10ps

module pm_top (
	input logic clk,
	input logic resetn,

	input logic [pm_pkg::apb_aw-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	input logic img_pulse,
	input logic img_valid,
	input logic [pm_pkg::img_w-1:0] img_pos,

	output logic [pm_pkg::step_w-1:0] pos_out,
	output logic running,
	output logic exe_done
);

	pm_pkg::cmd_word_t cmd;
	logic [pm_pkg::step_w-1:0] speed;
	logic [pm_pkg::frmn_w-1:0] delay_frm;
	logic go_pulse;
	logic lut_we;
	logic [pm_pkg::img_w-1:0] lut_addr;
	logic [pm_pkg::step_w-1:0] lut_wdata;
	logic over;

	logic [pm_pkg::step_w-1:0] movie_pos;
	logic img_start;
	logic err_valid, err_ok, err_back;
	logic [pm_pkg::step_w-1:0] err_steps;

	logic m_start, m_dir, m_running;
	logic [pm_pkg::step_w-1:0] m_step;
	logic [pm_pkg::step_w-1:0] m_position;

	assign pos_out = m_position;
	assign running = m_running;

	pm_apb_regs regs_inst (
		.clk(clk), .resetn(resetn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cmd(cmd), .speed(speed), .delay_frm(delay_frm), .go_pulse(go_pulse),
		.lut_we(lut_we), .lut_addr(lut_addr), .lut_wdata(lut_wdata),
		.done(exe_done), .over(over), .running(m_running)
	);

	pm_frame_history hist_inst (
		.clk(clk), .resetn(resetn), .img_pulse(img_pulse), .delay_frm(delay_frm),
		.m_position(m_position), .movie_pos(movie_pos)
	);

	pm_image_error err_inst (
		.clk(clk), .resetn(resetn), .start(img_start), .cmd(cmd), .img_pos(img_pos),
		.lut_we(lut_we), .lut_addr(lut_addr), .lut_wdata(lut_wdata),
		.err_valid(err_valid), .err_ok(err_ok), .err_back(err_back), .err_steps(err_steps)
	);

	pm_move_ctl ctl_inst (
		.clk(clk), .resetn(resetn), .go_pulse(go_pulse), .cmd(cmd),
		.img_pulse(img_pulse), .img_valid(img_valid),
		.err_valid(err_valid), .err_ok(err_ok), .err_back(err_back), .err_steps(err_steps),
		.movie_pos(movie_pos), .m_running(m_running), .img_start(img_start),
		.m_start(m_start), .m_step(m_step), .m_dir(m_dir),
		.exe_done(exe_done), .over(over)
	);

	pm_stepper stepper_inst (
		.clk(clk), .resetn(resetn), .m_start(m_start), .m_step(m_step), .m_dir(m_dir),
		.speed(speed), .m_running(m_running), .m_position(m_position)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the pm_tb simulation with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module pm_tb -f all.f -o pm_sim --Mdir obj_dir

./obj_dir/pm_sim | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* tests/pm_tb.sv */
`timescale 1ns/10ps

module pm_tb;

	localparam logic [31:0] spd = 32'd1;
	// each table write is a two-cycle access plus one idle cycle
	localparam int load_cycles = pm_pkg::lut_depth * 3;
	localparam int move_budget = 255 * 2 + 60;
	localparam int n_moves = 16;
	localparam int wd_cycles = load_cycles + n_moves * move_budget + 1000;

	logic clk = 1'b0;
	logic resetn;
	logic [pm_pkg::apb_aw-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic img_pulse;
	logic img_valid;
	logic [pm_pkg::img_w-1:0] img_pos;
	logic [pm_pkg::step_w-1:0] pos_out;
	logic running;
	logic exe_done;

	logic [31:0] lfsr_state = 32'hfd8f4bb3;
	logic [31:0] lut_model [pm_pkg::lut_depth];
	logic [31:0] exp_pos;

	pm_top pm_top_inst (
		.clk(clk), .resetn(resetn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.img_pulse(img_pulse), .img_valid(img_valid), .img_pos(img_pos),
		.pos_out(pos_out), .running(running), .exe_done(exe_done)
	);

	always #2 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAILED %0t %s expected %h got %h", $time, name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// setup cycle, access cycle, response sampled at the end of the access
	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
			input logic exp_err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		// no error response during setup
		check("pslverr", 32'd0, {31'd0, pslverr});
		penable <= 1'b1;
		@(posedge clk);
		check("pready", 32'd1, {31'd0, pready});
		check("pslverr", {31'd0, exp_err}, {31'd0, pslverr});
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, input logic exp_err,
			output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		check("pslverr", 32'd0, {31'd0, pslverr});
		penable <= 1'b1;
		@(posedge clk);
		check("pready", 32'd1, {31'd0, pready});
		check("pslverr", {31'd0, exp_err}, {31'd0, pslverr});
		data = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic frame(input logic [pm_pkg::img_w-1:0] pos, input logic valid);
		@(posedge clk);
		img_pulse <= 1'b1;
		img_valid <= valid;
		img_pos <= pos;
		@(posedge clk);
		img_pulse <= 1'b0;
		img_valid <= 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		// done from the previous move clears one cycle after go
		repeat (2) @(posedge clk);
		while (exe_done !== 1'b1) begin
			if (n >= limit) begin
				$display("exe_done did not rise within %0d cycles at %0t", limit, $time);
				$display("SOME TESTS FAILED");
				$fatal(1);
			end
			n++;
			@(posedge clk);
		end
	endtask

	task automatic check_end(input logic [31:0] exp_status);
		logic [31:0] st;
		check("pos_out", exp_pos, pos_out);
		check("running", 32'd0, {31'd0, running});
		apb_read(pm_pkg::addr_status, 1'b0, st);
		check("status", exp_status, st);
	endtask

	task automatic run_abs(input logic dir, input int steps);
		apb_write(pm_pkg::addr_cmd, {1'b0, dir, 30'(steps)}, 1'b0);
		apb_write(pm_pkg::addr_ctrl, 32'd1, 1'b0);
		wait_done(steps * (int'(spd) + 1) + 30);
		exp_pos = dir ? exp_pos - 32'(steps) : exp_pos + 32'(steps);
		check_end(32'h1);
	endtask

	task automatic run_img(input int pos, input int dst, input int tol, input logic dir);
		int err;
		logic back;
		logic [31:0] steps;
		logic [31:0] exp_st;
		back = pos < dst;
		err = back ? dst - pos : pos - dst;
		steps = 32'd0;
		exp_st = 32'h1;
		if (pos >= dst - tol && pos <= dst + tol) begin
			exp_st = 32'h1;
		end else if (back != dir) begin
			// over and done, no motion
			exp_st = 32'h3;
		end else begin
			steps = lut_model[err];
		end
		apb_write(pm_pkg::addr_cmd, {1'b1, dir, 12'(dst), 12'(tol), 6'd0}, 1'b0);
		apb_write(pm_pkg::addr_ctrl, 32'd1, 1'b0);
		frame(12'(pos), 1'b1);
		wait_done(int'(steps) * (int'(spd) + 1) + 40);
		exp_pos = back ? exp_pos - steps : exp_pos + steps;
		check_end(exp_st);
	endtask

	task automatic load_table();
		logic [31:0] v;
		for (int i = 0; i < pm_pkg::lut_depth; i++) begin
			v = {24'd0, rand_byte()};
			lut_model[i] = v;
			apb_write(pm_pkg::addr_lut_base + 16'(4 * i), v, 1'b0);
		end
	endtask

	task automatic test_regs();
		logic [31:0] rd;
		apb_write(pm_pkg::addr_speed, spd, 1'b0);
		apb_read(pm_pkg::addr_speed, 1'b0, rd);
		check("speed", spd, rd);
		apb_write(pm_pkg::addr_delay, 32'd2, 1'b0);
		apb_read(pm_pkg::addr_delay, 1'b0, rd);
		check("delay_frm", 32'd2, rd);
		apb_write(pm_pkg::addr_delay, 32'd0, 1'b0);
		apb_read(pm_pkg::addr_delay, 1'b0, rd);
		check("delay_frm", 32'd0, rd);
		apb_write(pm_pkg::addr_cmd, 32'h1234_5678, 1'b0);
		apb_read(pm_pkg::addr_cmd, 1'b0, rd);
		check("cmd", 32'h1234_5678, rd);
		// bad accesses
		apb_read(16'h0020, 1'b1, rd);
		apb_write(16'h0024, 32'h0, 1'b1);
		apb_write(pm_pkg::addr_status, 32'h7, 1'b1);
	endtask

	task automatic test_delay(input logic [31:0] dly);
		apb_write(pm_pkg::addr_delay, dly, 1'b0);
		for (int k = 0; k < 3; k++) begin
			frame(12'd0, 1'b0);
			run_abs(1'b0, 5 + k);
		end
		run_img(300, 200, 8, 1'b0);
	endtask

	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

	initial begin
		resetn = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		img_pulse = 1'b0;
		img_valid = 1'b0;
		img_pos = '0;
		exp_pos = '0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		test_regs();
		load_table();

		run_abs(1'b0, 25);
		run_abs(1'b1, 10);
		// goes negative
		run_abs(1'b1, 40);

		run_img(500, 510, 16, 1'b0);
		run_img(400, 510, 16, 1'b1);
		run_img(700, 510, 16, 1'b0);
		run_img(400, 510, 16, 1'b0);

		test_delay(32'd3);
		test_delay(32'd1);

		// every failed check has already stopped the run
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
